// ==== logic/fpcast_pkg.sv ====
// Float and integer cast definitions
`default_nettype none

package fpcast_pkg;

  // ----------------------------------------
  // Widths and constants
  // ----------------------------------------
  localparam int unsigned DATA_WIDTH  = 32;  // Operand and result width
  localparam int unsigned EXP_BITS    = 8;   // binary32 exponent field
  localparam int unsigned MAN_BITS    = 23;  // binary32 mantissa field
  localparam int unsigned BIAS        = 127;
  // Internal mantissa holds the hidden bit or a whole integer
  localparam int unsigned MANT_WIDTH  = (MAN_BITS + 1 > DATA_WIDTH) ? MAN_BITS + 1 : DATA_WIDTH;
  localparam int unsigned EXP_WIDTH   = 10;  // Down to the smallest subnormal, signed
  localparam int unsigned SHAMT_WIDTH = 5;   // Leading-zero count

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic        [DATA_WIDTH-1:0] data_t;
  typedef logic        [MANT_WIDTH-1:0] mant_t;
  typedef logic signed [EXP_WIDTH-1:0]  exp_t;   // Unbiased exponent
  typedef logic        [3:0]            tag_t;

  typedef enum logic [2:0] {
    RNE = 3'b000,  // Nearest, ties to even
    RTZ = 3'b001,  // Toward zero
    RDN = 3'b010,  // Toward minus infinity
    RUP = 3'b011,  // Toward plus infinity
    RMM = 3'b100   // Nearest, ties away from zero
  } round_mode_e;

  typedef enum logic {
    OP_F2I = 1'b0,
    OP_I2F = 1'b1
  } cast_op_e;

  // IEEE exception flags
  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero, never raised here
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // Float operand class
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  typedef struct packed {
    data_t       operand;
    cast_op_e    op;
    logic        is_unsigned;
    round_mode_e rnd_mode;
    tag_t        tag;
  } cast_req_t;

  // Operand after normalization, leading one at the top of mant
  typedef struct packed {
    logic        sign;
    exp_t        exp;
    mant_t       mant;
    logic        mant_zero;
    fp_info_t    info;
    cast_op_e    op;
    logic        is_unsigned;
    round_mode_e rnd_mode;
    tag_t        tag;
  } norm_op_t;

  typedef struct packed {
    data_t   result;
    status_t status;
    tag_t    tag;
  } cast_rsp_t;

endpackage

`default_nettype wire

// ==== logic/fpcast_normalizer.sv ====
// Cast operand classifier and normalizer
`timescale 1ns/10ps
`default_nettype none

module fpcast_normalizer import fpcast_pkg::*; (
  input  cast_req_t req_i,
  output norm_op_t  norm_o
);

  // Offset between the float mantissa and the internal mantissa width
  localparam int unsigned SHIFT_COMP = MANT_WIDTH - 1 - MAN_BITS;

  // ----------------------------------------
  // Float classification
  // ----------------------------------------
  logic [EXP_BITS-1:0] exp_field;
  logic [MAN_BITS-1:0] man_field;
  logic                exp_zero;
  logic                exp_ones;
  logic                man_zero;
  fp_info_t            info;

  assign exp_field = req_i.operand[MAN_BITS +: EXP_BITS];
  assign man_field = req_i.operand[MAN_BITS-1:0];
  assign exp_zero  = (exp_field == '0);
  assign exp_ones  = (exp_field == '1);
  assign man_zero  = (man_field == '0);

  always_comb begin : classify
    info.is_zero       = exp_zero & man_zero;
    info.is_subnormal  = exp_zero & ~man_zero;
    info.is_normal     = ~exp_zero & ~exp_ones;
    info.is_inf        = exp_ones & man_zero;
    info.is_nan        = exp_ones & ~man_zero;
    info.is_signalling = exp_ones & ~man_zero & ~man_field[MAN_BITS-1];  // Quiet bit clear
  end

  // ----------------------------------------
  // Mantissa selection
  // ----------------------------------------
  logic  is_i2f;
  logic  int_sign;
  mant_t int_mant;
  mant_t fp_mant;
  mant_t enc_mant;

  assign is_i2f   = (req_i.op == OP_I2F);
  assign int_sign = req_i.operand[DATA_WIDTH-1] & ~req_i.is_unsigned;  // Signed ints only
  assign int_mant = int_sign ? mant_t'(-req_i.operand) : mant_t'(req_i.operand);
  assign fp_mant  = mant_t'({info.is_normal, man_field});  // Hidden bit, zero padded on top
  assign enc_mant = is_i2f ? int_mant : fp_mant;

  // ----------------------------------------
  // Leading-zero count and shift
  // ----------------------------------------
  logic [SHAMT_WIDTH-1:0] lz_cnt;

  always_comb begin : lzc
    lz_cnt = '0;
    // Highest set bit wins
    for (int i = 0; i < MANT_WIDTH; i++) begin
      if (enc_mant[i]) begin
        lz_cnt = SHAMT_WIDTH'(MANT_WIDTH - 1 - i);
      end
    end
  end

  // Unbiased exponent for each source
  exp_t fp_exp;
  exp_t int_exp;
  exp_t lz_sgn;

  assign lz_sgn  = $signed({{(EXP_WIDTH-SHAMT_WIDTH){1'b0}}, lz_cnt});
  assign fp_exp  = $signed({{(EXP_WIDTH-EXP_BITS){1'b0}}, exp_field})
                 + $signed({{(EXP_WIDTH-1){1'b0}}, info.is_subnormal})  // Subnormals use exp 1
                 - exp_t'(BIAS)
                 - lz_sgn
                 + exp_t'(SHIFT_COMP);
  assign int_exp = exp_t'(MANT_WIDTH - 1) - lz_sgn;

  always_comb begin : pack_out
    norm_o.sign        = is_i2f ? int_sign : req_i.operand[DATA_WIDTH-1];
    norm_o.exp         = is_i2f ? int_exp : fp_exp;
    norm_o.mant        = enc_mant << lz_cnt;        // Leading one to the top
    norm_o.mant_zero   = (enc_mant == '0);          // Integer zero
    norm_o.info        = info;
    norm_o.op          = req_i.op;
    norm_o.is_unsigned = req_i.is_unsigned;
    norm_o.rnd_mode    = req_i.rnd_mode;
    norm_o.tag         = req_i.tag;
  end

endmodule

`default_nettype wire

// ==== logic/fpcast_stage_pipe.sv ====
// Valid/ready register stage chain
`timescale 1ns/10ps
`default_nettype none

module fpcast_stage_pipe import fpcast_pkg::*; #(
  parameter int unsigned DEPTH = 2  // Number of register stages, 1 or more
) (
  input  wire      clk_i,
  input  wire      rst_i,
  input  wire      in_valid_i,
  output logic     in_ready_o,
  input  norm_op_t in_data_i,
  output logic     out_valid_o,
  input  wire      out_ready_i,
  output norm_op_t out_data_o
);

  logic     [DEPTH-1:0] valid_q;      // Stage i register
  norm_op_t [DEPTH-1:0] data_q;
  logic     [DEPTH:0]   valid_chain;  // Index i feeds stage i, index DEPTH is the output
  norm_op_t [DEPTH:0]   data_chain;
  logic     [DEPTH:0]   stage_ready;  // Stage i may load

  assign valid_chain = {valid_q, in_valid_i};
  assign data_chain  = {data_q, in_data_i};

  // Ready ripples back from the consumer
  always_comb begin : ready_chain
    stage_ready[DEPTH] = out_ready_i;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      // Pass on when downstream takes it or only a bubble sits there
      stage_ready[i] = stage_ready[i+1] | ~valid_chain[i+1];
    end
  end

  always_ff @(posedge clk_i) begin : valid_regs
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (stage_ready[i]) begin
          valid_q[i] <= valid_chain[i];
        end
      end
    end
  end

  // Payload loads only with a valid item
  always_ff @(posedge clk_i) begin : data_regs
    for (int i = 0; i < DEPTH; i++) begin
      if (stage_ready[i] && valid_chain[i]) begin
        data_q[i] <= data_chain[i];
      end
    end
  end

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = valid_chain[DEPTH];
  assign out_data_o  = data_chain[DEPTH];

endmodule

`default_nettype wire

// ==== logic/fpcast_rounder.sv ====
// Cast shifter and rounder
`timescale 1ns/10ps
`default_nettype none

module fpcast_rounder import fpcast_pkg::*; (
  input  norm_op_t  op_i,
  output cast_rsp_t rsp_o
);

  localparam int unsigned SHIFT_WIDTH = SHAMT_WIDTH + 1;              // Up to DATA_WIDTH+1
  localparam int unsigned FP_STICKY   = 2 * MANT_WIDTH - MAN_BITS - 1;  // Below float R bit
  localparam int unsigned INT_STICKY  = 2 * MANT_WIDTH - DATA_WIDTH;    // Below int R bit

  logic to_int;
  exp_t dst_exp;  // Rebiased for binary32

  assign to_int  = (op_i.op == OP_F2I);
  assign dst_exp = op_i.exp + exp_t'(BIAS);

  // ----------------------------------------
  // Placement and range checks
  // ----------------------------------------
  logic [EXP_BITS-1:0]    final_exp;
  logic [2*MANT_WIDTH:0]  preshift_mant;
  logic [2*MANT_WIDTH:0]  dest_mant;
  logic [SHIFT_WIDTH-1:0] denorm_shamt;
  logic                   of_before_round;
  logic                   uf_before_round;

  always_comb begin : cast_value
    final_exp       = dst_exp[EXP_BITS-1:0];
    preshift_mant   = {op_i.mant, {(MANT_WIDTH+1){1'b0}}};  // Left end of the shifter
    denorm_shamt    = '0;
    of_before_round = 1'b0;
    uf_before_round = 1'b0;
    if (to_int) begin
      denorm_shamt = SHIFT_WIDTH'(exp_t'(DATA_WIDTH - 1) - op_i.exp);  // Binary point to bit 0
      // Unsigned range is one bit larger
      if (op_i.exp >= exp_t'(DATA_WIDTH - 1) + exp_t'(op_i.is_unsigned)) begin
        denorm_shamt    = '0;
        of_before_round = 1'b1;
      end else if (op_i.exp < exp_t'(-1)) begin
        denorm_shamt    = SHIFT_WIDTH'(DATA_WIDTH + 1);  // Everything into sticky
        uf_before_round = 1'b1;
      end
    end else if (dst_exp < exp_t'(1)) begin
      // Subnormal float result
      final_exp       = '0;
      uf_before_round = 1'b1;
      if (dst_exp < exp_t'(-int'(MAN_BITS))) begin
        denorm_shamt = SHIFT_WIDTH'(MAN_BITS + 2);  // Keep sticky alive
      end else begin
        denorm_shamt = SHIFT_WIDTH'(exp_t'(1) - dst_exp);
      end
    end
  end

  // ----------------------------------------
  // Round and sticky extraction
  // ----------------------------------------
  logic [MAN_BITS-1:0] final_mant;
  data_t               final_int;
  logic [1:0]          fp_rs;
  logic [1:0]          int_rs;
  logic [1:0]          rs;
  data_t               pre_round_abs;

  assign dest_mant = preshift_mant >> denorm_shamt;
  assign {final_mant, fp_rs[1]} = dest_mant[2*MANT_WIDTH-1 -: MAN_BITS+1];  // Drops hidden bit
  assign {final_int, int_rs[1]} = dest_mant[2*MANT_WIDTH -: DATA_WIDTH+1];
  assign fp_rs[0]  = |dest_mant[FP_STICKY-1:0];
  assign int_rs[0] = |dest_mant[INT_STICKY-1:0];
  assign rs        = to_int ? int_rs : fp_rs;

  assign pre_round_abs = to_int ? final_int : data_t'({final_exp, final_mant});

  // ----------------------------------------
  // Rounding
  // ----------------------------------------
  logic  round_up;
  data_t rounded_abs;

  always_comb begin : round_sel
    unique case (op_i.rnd_mode)
      RNE:     round_up = rs[1] & (rs[0] | pre_round_abs[0]);  // Tie goes to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs) & op_i.sign;
      RUP:     round_up = (|rs) & ~op_i.sign;
      RMM:     round_up = rs[1];                               // Tie goes away from zero
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_round_abs + data_t'(round_up);  // Carry may bump the exponent

  // Two's complement for negative integers
  data_t rounded_int_res;
  data_t fp_result;

  assign rounded_int_res = op_i.sign ? -rounded_abs : rounded_abs;
  assign fp_result = op_i.mant_zero ? '0 : {op_i.sign, rounded_abs[DATA_WIDTH-2:0]};

  // ----------------------------------------
  // Integer special cases
  // ----------------------------------------
  data_t int_special_res;
  logic  int_is_special;

  always_comb begin : int_special
    int_special_res = {op_i.is_unsigned, {(DATA_WIDTH-1){1'b1}}};  // Positive limit
    // Negative limit, NaN stays positive
    if (op_i.sign && !op_i.info.is_nan) begin
      int_special_res = ~int_special_res;
    end
  end

  assign int_is_special = op_i.info.is_nan | op_i.info.is_inf | of_before_round
                        | (op_i.sign & op_i.is_unsigned & (rounded_int_res != '0));

  // ----------------------------------------
  // Result and flags
  // ----------------------------------------
  status_t fp_status;
  status_t int_status;
  data_t   int_result;

  // 32-bit integers never reach the float overflow range
  assign fp_status = '{nv: 1'b0, dz: 1'b0, of: 1'b0,
                       uf: uf_before_round & (|fp_rs),  // Tiny and inexact
                       nx: |fp_rs};
  assign int_status = int_is_special ? '{nv: 1'b1, default: 1'b0}
                                     : '{nx: |int_rs, default: 1'b0};
  assign int_result = int_is_special ? int_special_res : rounded_int_res;

  assign rsp_o = '{result: to_int ? int_result : fp_result,
                   status: to_int ? int_status : fp_status,
                   tag:    op_i.tag};

endmodule

`default_nettype wire

// ==== logic/fpcast_top.sv ====
// Pipelined float and integer converter
`timescale 1ns/10ps
`default_nettype none

module fpcast_top import fpcast_pkg::*; #(
  parameter int unsigned PIPE_DEPTH = 2  // Register stages between normalizer and rounder
) (
  input  wire       clk_i,
  input  wire       rst_i,
  // Request side
  input  cast_req_t req_i,
  input  wire       req_valid_i,
  output logic      req_ready_o,
  // Response side
  output cast_rsp_t rsp_o,
  output logic      rsp_valid_o,
  input  wire       rsp_ready_i
);

  norm_op_t norm_in;   // Straight from the normalizer
  norm_op_t norm_out;  // After PIPE_DEPTH stages

  // ----------------------------------------
  // Classify and normalize
  // ----------------------------------------
  fpcast_normalizer i_normalizer (
    .req_i  (req_i),
    .norm_o (norm_in)
  );

  // ----------------------------------------
  // Stage registers and handshake
  // ----------------------------------------
  fpcast_stage_pipe #(
    .DEPTH (PIPE_DEPTH)
  ) i_stage_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),  // Combinational from rsp_ready_i
    .in_data_i   (norm_in),
    .out_valid_o (rsp_valid_o),
    .out_ready_i (rsp_ready_i),
    .out_data_o  (norm_out)
  );

  // ----------------------------------------
  // Cast, round and select specials
  // ----------------------------------------
  fpcast_rounder i_rounder (
    .op_i  (norm_out),
    .rsp_o (rsp_o)
  );

endmodule

`default_nettype wire

// ==== sim/fpcast_clkgen.sv ====
// Test clock and reset
`timescale 1ns/10ps
`default_nettype none

module fpcast_clkgen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on an edge
  end

endmodule

`default_nettype wire

// ==== sim/fpcast_properties.sv ====
// Converter handshake assertions
`timescale 1ns/10ps
`default_nettype none

module fpcast_properties import fpcast_pkg::*; (
  input wire       clk_i,
  input wire       rst_i,
  input cast_req_t req_i,
  input wire       req_valid_i,
  input wire       req_ready_i,
  input cast_rsp_t rsp_i,
  input wire       rsp_valid_i,
  input wire       rsp_ready_i
);

  int unsigned n_fail = 0;  // Failed assertions so far, watched by the testbench

  // Stalled response holds valid and data
  rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
      n_fail++;
      $error("Response changed while stalled");
    end

  // Stalled request holds valid and data
  req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else begin
      n_fail++;
      $error("Request changed while stalled");
    end

  // Once reset has taken hold, nothing leaves
  rst_quiet: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !rsp_valid_i)
    else begin
      n_fail++;
      $error("Response valid during reset");
    end

endmodule

bind fpcast_top fpcast_properties i_properties (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_i       (req_i),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .rsp_i       (rsp_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i)
);

`default_nettype wire

// ==== sim/fpcast_tb.sv ====
// Converter testbench
`timescale 1ns/10ps
`default_nettype none

module fpcast_tb import fpcast_pkg::*; ();

  localparam int MAX_VEC = 64;
  localparam int TIMEOUT = 200;  // Cycles per wait

  logic      clk;
  logic      rst;
  cast_req_t req;
  logic      req_valid;
  logic      req_ready;
  cast_rsp_t rsp;
  logic      rsp_valid;
  logic      rsp_ready;

  // Vector table
  logic       v_op   [MAX_VEC];
  logic       v_uns  [MAX_VEC];
  logic [2:0] v_rnd  [MAX_VEC];
  data_t      v_opnd [MAX_VEC];
  data_t      v_res  [MAX_VEC];
  logic [4:0] v_stat [MAX_VEC];
  int         n_vec;
  int         n_rcv;

  cast_rsp_t exp_q[$];  // In request order
  integer    seed;
  logic      stall_pat [256];
  int        idle_pat  [MAX_VEC];
  int        cyc;

  fpcast_clkgen i_clkgen (.clk_o(clk), .rst_o(rst));

  fpcast_top #(.PIPE_DEPTH(2)) dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input data_t got, input data_t expected, input string what);
    if (got !== expected) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
      $display(">>> FAIL");
      $fatal(1, "Mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s at %0t", what, $time);
    $display(">>> FAIL");
    $fatal(1, "Timeout");
  endtask

  task automatic load_vectors;
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f_op, f_uns, f_rnd, f_opnd, f_res, f_stat;
    fd = $fopen("sim/fpcast_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      $display(">>> FAIL");
      $fatal(1, "No stimulus");
    end
    n_vec = 0;
    while ($fgets(line, fd) > 0) begin
      cnt = $sscanf(line, "%h %h %h %h %h %h", f_op, f_uns, f_rnd, f_opnd, f_res, f_stat);
      if (cnt == 6 && n_vec < MAX_VEC) begin  // Comment lines scan nothing
        v_op[n_vec]   = f_op[0];
        v_uns[n_vec]  = f_uns[0];
        v_rnd[n_vec]  = f_rnd[2:0];
        v_opnd[n_vec] = f_opnd;
        v_res[n_vec]  = f_res;
        v_stat[n_vec] = f_stat[4:0];
        n_vec++;
      end
    end
    $fclose(fd);
  endtask

  // Drive one request and wait until it is taken
  task automatic send_request(input int idx);
    int cycles;
    if (idle_pat[idx] > 0) begin
      req_valid <= 1'b0;
      repeat (idle_pat[idx]) @(posedge clk);
    end
    req_valid <= 1'b1;
    req <= '{operand: v_opnd[idx], op: cast_op_e'(v_op[idx]), is_unsigned: v_uns[idx],
             rnd_mode: round_mode_e'(v_rnd[idx]), tag: tag_t'(idx)};
    cycles = 0;
    @(posedge clk);
    while (!req_ready) begin
      cycles++;
      if (cycles > TIMEOUT) stop_on_timeout("request accept");
      @(posedge clk);
    end
    exp_q.push_back(cast_rsp_t'{result: v_res[idx], status: status_t'(v_stat[idx]),
                                tag: tag_t'(idx)});
  endtask

  // ----------------------------------------
  // Back-pressure and response check
  // ----------------------------------------
  always @(posedge clk) begin : stall_drive
    rsp_ready <= stall_pat[cyc % 256];
    cyc++;
  end

  always @(posedge clk) begin : check_rsp
    cast_rsp_t want;
    if (!rst && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no request pending");
        $display(">>> FAIL");
        $fatal(1, "Extra response");
      end
      want = exp_q.pop_front();
      check_value(data_t'(rsp.tag), data_t'(want.tag), "tag");
      check_value(rsp.result, want.result, "result");
      check_value(data_t'(rsp.status), data_t'(want.status), "status");
      n_rcv++;
    end
  end

  // Bound handshake assertions count their failures
  always @(posedge clk) begin : assert_watch
    if (dut.i_properties.n_fail != 0) begin
      $display("A handshake assertion failed at %0t", $time);
      $display(">>> FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main
    int cycles;
    req       <= '0;
    req_valid <= 1'b0;
    rsp_ready <= 1'b0;
    cyc   = 0;
    n_rcv = 0;
    seed  = 2;
    for (int i = 0; i < 256; i++) begin
      stall_pat[i] = (($random(seed) & 3) != 0);  // Ready three times in four
    end
    for (int i = 0; i < MAX_VEC; i++) begin
      idle_pat[i] = $unsigned($random(seed)) % 3;
    end
    load_vectors();

    cycles = 0;
    @(posedge clk);
    while (rst) begin
      cycles++;
      if (cycles > TIMEOUT) stop_on_timeout("reset release");
      @(posedge clk);
    end
    check_value(data_t'(rsp_valid), 32'd0, "rsp_valid_o after reset");
    check_value(data_t'(req_ready), 32'd1, "req_ready_o after reset");

    for (int i = 0; i < n_vec; i++) begin
      send_request(i);
    end
    req_valid <= 1'b0;

    cycles = 0;
    while (n_rcv < n_vec) begin
      cycles++;
      if (cycles > TIMEOUT) stop_on_timeout("last responses");
      @(posedge clk);
    end

    if (exp_q.size() == 0 && n_vec > 0 && dut.i_properties.n_fail == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("No vectors run, responses left over or an assertion failed");
      $display(">>> FAIL");
      $fatal(1, "Incomplete run");
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/fpcast_pkg.sv
logic/fpcast_normalizer.sv
logic/fpcast_stage_pipe.sv
logic/fpcast_rounder.sv
logic/fpcast_top.sv
sim/fpcast_clkgen.sv
sim/fpcast_properties.sv
sim/fpcast_tb.sv

// ==== Makefile ====
# Verilator flow for the float and integer converter

VERILATOR ?= verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = fpcast_tb
FILELIST   = build.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = >>> FAIL
PASS_MSG   = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/fpcast_stim.txt ====
# op(0=F2I 1=I2F) unsigned rnd(0=RNE 1=RTZ 2=RDN 3=RUP 4=RMM) operand result status
# All fields hex, status bits are nv dz of uf nx
0 0 0 40200000 00000002 01
0 0 1 40200000 00000002 01
0 0 2 40200000 00000002 01
0 0 3 40200000 00000003 01
0 0 4 40200000 00000003 01
0 0 0 C0200000 FFFFFFFE 01
0 0 1 C0200000 FFFFFFFE 01
0 0 2 C0200000 FFFFFFFD 01
0 0 3 C0200000 FFFFFFFE 01
0 0 4 C0200000 FFFFFFFD 01
0 0 0 40600000 00000004 01
0 0 0 3F000000 00000000 01
0 0 4 3F000000 00000001 01
0 0 0 BFC00000 FFFFFFFE 01
0 0 1 3F800000 00000001 00
0 0 0 4B000001 00800001 00
0 1 1 4F7FFFFF FFFFFF00 00
0 0 0 7FC00000 7FFFFFFF 10
0 1 0 7FC00000 FFFFFFFF 10
0 0 0 7F800000 7FFFFFFF 10
0 0 0 FF800000 80000000 10
0 1 0 7F800000 FFFFFFFF 10
0 1 0 FF800000 00000000 10
0 0 0 4F000000 7FFFFFFF 10
0 1 1 4F000000 80000000 00
0 1 0 4F800000 FFFFFFFF 10
0 1 1 BF800000 00000000 10
0 1 1 BE800000 00000000 01
0 0 0 00000001 00000000 01
0 0 1 80400000 00000000 01
0 0 0 00000000 00000000 00
1 0 0 00000000 00000000 00
1 0 0 00000001 3F800000 00
1 0 0 FFFFFFFF BF800000 00
1 0 0 80000000 CF000000 00
1 0 0 7FFFFFFF 4F000000 01
1 0 1 7FFFFFFF 4EFFFFFF 01
1 1 0 FFFFFFFF 4F800000 01
1 1 1 FFFFFFFF 4F7FFFFF 01
1 1 0 01000001 4B800000 01
1 1 3 01000001 4B800001 01
1 1 4 01000001 4B800001 01
1 1 2 01000001 4B800000 01
1 1 0 01000003 4B800002 01
1 0 0 FEFFFFFF CB800000 01
1 0 2 FEFFFFFF CB800001 01
1 0 3 FEFFFFFF CB800000 01
1 0 4 FEFFFFFF CB800001 01
1 0 1 FEFFFFFF CB800000 01
